// ==== Makefile ====
SIM  := obj_dir/Vtb_soc_fabric
SRCS := $(wildcard design/*.sv bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS)
	verilator --binary --timing --timescale 1ns/10ps --top-module tb_soc_fabric -f build.f

run: $(SIM)
	$(SIM) | tee sim.log
	@! grep -q "Test failed" sim.log
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_soc_fabric.sv ====
// Fabric self-checking testbench
`timescale 1ns/10ps

module tb_soc_fabric;

  import soc_pkg::*;

  // DUT defaults and test lengths
  localparam int RAM_WORDS    = 1024;
  localparam int RESP_LATENCY = 4;
  localparam int IDX_W        = $clog2(RAM_WORDS);
  localparam int N_RAND       = 150;
  localparam int N_MIX        = 120;
  localparam int N_UNM        = 40;
  // Requests of all phases including the fixed CLINT sequences
  localparam int N_REQ        = RAM_WORDS + 3 * N_RAND + N_MIX + 2 * N_UNM + 23;
  // Address bits that pick the RAM word
  localparam logic [31:0] IDX_MASK = 32'((RAM_WORDS - 1) * 4);

  logic     clk_i = 1'b0;
  logic     rst_ni;
  bus_req_t req;
  bus_rsp_t rsp;
  logic     timer_irq;
  logic     sw_irq;

  // Reference model state
  logic [31:0] ram_m [RAM_WORDS];
  logic [63:0] cmp_m;
  logic        msip_m;
  logic [63:0] mt_base;
  int          mt_cyc;

  int       cyc = 0;
  int       seed = 32'ha3c7_6146;
  int       mism_cnt = 0;
  int       fail_cnt = 0;
  int       exp_due [$];
  bus_rsp_t exp_rsp [$];

  soc_fabric dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req),
    .rsp_o       (rsp),
    .timer_irq_o (timer_irq),
    .sw_irq_o    (sw_irq)
  );

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // ========================================
  // Reference model
  // ========================================
  // One count per cycle since the last load
  function automatic logic [63:0] mtime_at(input int c);
    return mt_base + 64'(c - mt_cyc);
  endfunction

  function automatic bus_rsp_t ref_access(input bus_req_t r, input int c);
    bus_rsp_t         rsp_e;
    logic [63:0]      mt;
    logic [31:0]      rd;
    logic [31:0]      word;
    logic [IDX_W-1:0] idx;
    logic [15:0]      off;
    logic             wr;
    rsp_e       = '0;
    rsp_e.valid = 1'b1;
    wr          = |r.wstrb;
    mt          = mtime_at(c);
    word        = r.addr >> 2;
    idx         = word[IDX_W-1:0];
    off         = r.addr[15:0];
    rd          = '0;
    if (r.addr[31]) begin
      // RAM aliased by the word index
      for (int b = 0; b < 4; b++) begin
        if (r.wstrb[b]) begin
          ram_m[idx][8*b +: 8] = r.wdata[8*b +: 8];
        end
      end
      rd = ram_m[idx];
    end else if (r.addr[31:28] == 4'h3) begin
      case (off)
        CLINT_MSIP_OFF:             rd = {31'b0, msip_m};
        CLINT_MTIMECMP_OFF:         rd = cmp_m[31:0];
        CLINT_MTIMECMP_OFF + 16'd4: rd = cmp_m[63:32];
        CLINT_MTIME_OFF:            rd = mt[31:0];
        CLINT_MTIME_OFF + 16'd4:    rd = mt[63:32];
        default:                    rd = '0;
      endcase
      if (wr) begin
        case (off)
          CLINT_MSIP_OFF:             msip_m = r.wdata[0];
          CLINT_MTIMECMP_OFF:         cmp_m[31:0] = r.wdata;
          CLINT_MTIMECMP_OFF + 16'd4: cmp_m[63:32] = r.wdata;
          CLINT_MTIME_OFF:            mt_base = {mt[63:32], r.wdata};
          CLINT_MTIME_OFF + 16'd4:    mt_base = {r.wdata, mt[31:0]};
          default:                    ;
        endcase
        // Loaded value holds from the next cycle
        if (off == CLINT_MTIME_OFF || off == CLINT_MTIME_OFF + 16'd4) begin
          mt_cyc = c + 1;
        end
      end
    end else begin
      rsp_e.err = 1'b1;
    end
    rsp_e.rdata = (wr || rsp_e.err) ? 32'h0 : rd;
    return rsp_e;
  endfunction

  // ========================================
  // Stimulus helpers
  // ========================================
  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [31:0] ram_addr(input logic [31:0] v);
    return {1'b1, v[30:2], 2'b00};
  endfunction

  function automatic logic [31:0] clint_addr(input logic [15:0] off);
    return MMAP_CLINT_BASE | {16'h0, off};
  endfunction

  // Never all zero, so it stays a write
  function automatic logic [3:0] strb(input logic [31:0] v);
    return (v[3:0] == 4'h0) ? 4'hF : v[3:0];
  endfunction

  // One-cycle request strobe and its expected response with the due cycle
  task automatic issue(input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [3:0] wstrb);
    bus_req_t r;
    @(posedge clk_i);
    #1;
    r.valid = 1'b1;
    r.addr  = addr;
    r.wdata = wdata;
    r.wstrb = wstrb;
    req     = r;
    exp_rsp.push_back(ref_access(r, cyc));
    exp_due.push_back(cyc + RESP_LATENCY);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      req = '0;
    end
  endtask

  task automatic check_irqs(input logic exp_timer, input logic exp_sw);
    if (timer_irq !== exp_timer || sw_irq !== exp_sw) begin
      $display("mismatch at %0t: timer_irq %b sw_irq %b, expected %b %b",
               $time, timer_irq, sw_irq, exp_timer, exp_sw);
      mism_cnt++;
    end
  endtask

  // Write a CLINT register, then check both interrupts a cycle later
  task automatic write_and_check(input logic [15:0] off, input logic [31:0] data,
                                 input logic exp_timer, input logic exp_sw);
    issue(clint_addr(off), data, 4'hF);
    idle(1);
    check_irqs(exp_timer, exp_sw);
  endtask

  // ========================================
  // Response comparison
  // ========================================
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (exp_due.size() != 0 && exp_due[0] == cyc) begin
        if (!rsp.valid) begin
          $display("no response at %0t for a request due in cycle %0d", $time, cyc);
          fail_cnt++;
        end else if (rsp !== exp_rsp[0]) begin
          $display("mismatch at %0t: err %b rdata %h, expected err %b rdata %h",
                   $time, rsp.err, rsp.rdata, exp_rsp[0].err, exp_rsp[0].rdata);
          mism_cnt++;
        end
        void'(exp_due.pop_front());
        void'(exp_rsp.pop_front());
      end else if (rsp.valid !== 1'b0) begin
        $display("unexpected response at %0t with no request due", $time);
        fail_cnt++;
      end
    end
  end

  // Watchdog with four cycles per request plus slack
  initial begin
    #(100 * (N_REQ * 4 + 200));
    $display("watchdog expired before all responses were checked");
    $display("Test failed");
    $finish;
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] v;
    rst_ni  = 1'b0;
    req     = '0;
    cmp_m   = '1;
    msip_m  = 1'b0;
    mt_base = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    mt_cyc = cyc;
    check_irqs(1'b0, 1'b0);

    // Known pattern in every word
    for (int i = 0; i < RAM_WORDS; i++) begin
      a = MMAP_RAM_BASE + 32'(i * 4);
      issue(a, a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3, 4'hF);
    end
    check_irqs(1'b0, 1'b0);

    // Byte writes, aliased reads, random reads
    for (int i = 0; i < N_RAND; i++) begin
      a = ram_addr(rnd());
      issue(a, rnd(), strb(rnd()));
      v = rnd();
      issue(32'h8000_0000 | (v & ~IDX_MASK & 32'h7fff_fffc) | (a & IDX_MASK), 32'h0, 4'h0);
      issue(ram_addr(rnd()), 32'h0, 4'h0);
    end

    // Back-to-back mix of RAM and CLINT
    for (int i = 0; i < N_MIX; i++) begin
      v = rnd();
      case (v[2:0])
        3'd0, 3'd1: issue(ram_addr(rnd()), 32'h0, 4'h0);
        3'd2:       issue(ram_addr(rnd()), rnd(), strb(rnd()));
        3'd3:       issue(clint_addr(CLINT_MTIME_OFF), 32'h0, 4'h0);
        3'd4:       issue(clint_addr(CLINT_MTIME_OFF + 16'd4), 32'h0, 4'h0);
        3'd5:       issue(clint_addr(CLINT_MTIMECMP_OFF), 32'h0, 4'h0);
        3'd6:       issue(clint_addr(CLINT_MSIP_OFF), 32'h0, 4'h0);
        default:    issue(clint_addr(CLINT_MTIMECMP_OFF + 16'd4), 32'h0, 4'h0);
      endcase
    end

    // mtime load and later read, mtimecmp readback
    issue(clint_addr(CLINT_MTIME_OFF), rnd(), 4'hF);
    issue(clint_addr(CLINT_MTIME_OFF + 16'd4), rnd(), 4'hF);
    idle(17);
    issue(clint_addr(CLINT_MTIME_OFF), 32'h0, 4'h0);
    issue(clint_addr(CLINT_MTIME_OFF + 16'd4), 32'h0, 4'h0);
    issue(clint_addr(CLINT_MTIMECMP_OFF), rnd(), 4'hF);
    issue(clint_addr(CLINT_MTIMECMP_OFF + 16'd4), rnd(), 4'hF);
    issue(clint_addr(CLINT_MTIMECMP_OFF), 32'h0, 4'h0);
    issue(clint_addr(CLINT_MTIMECMP_OFF + 16'd4), 32'h0, 4'h0);

    // Interrupts with a small mtime so the high half of mtimecmp decides
    issue(clint_addr(CLINT_MTIME_OFF + 16'd4), 32'h0, 4'hF);
    issue(clint_addr(CLINT_MTIME_OFF), 32'h100, 4'hF);
    write_and_check(CLINT_MTIMECMP_OFF + 16'd4, 32'hffff_ffff, 1'b0, 1'b0);
    write_and_check(CLINT_MTIMECMP_OFF, 32'h0, 1'b0, 1'b0);
    write_and_check(CLINT_MTIMECMP_OFF + 16'd4, 32'h0, 1'b1, 1'b0);
    write_and_check(CLINT_MTIMECMP_OFF + 16'd4, 32'h1, 1'b0, 1'b0);
    write_and_check(CLINT_MSIP_OFF, 32'h1, 1'b0, 1'b1);
    write_and_check(CLINT_MSIP_OFF, 32'hffff_fffe, 1'b0, 1'b0);
    write_and_check(CLINT_MSIP_OFF, 32'h3, 1'b0, 1'b1);
    write_and_check(CLINT_MSIP_OFF, 32'h0, 1'b0, 1'b0);
    issue(clint_addr(CLINT_MTIMECMP_OFF + 16'd4), 32'h0, 4'h0);
    issue(clint_addr(CLINT_MSIP_OFF), 32'h0, 4'h0);
    issue(clint_addr(CLINT_MTIME_OFF), 32'h0, 4'h0);

    // Unmapped space with region 3 moved to 2
    for (int i = 0; i < N_UNM; i++) begin
      v = rnd();
      a = {1'b0, v[30:2], 2'b00};
      if (a[31:28] == 4'h3) begin
        a[28] = 1'b0;
      end
      issue(a, rnd(), v[0] ? strb(rnd()) : 4'h0);
      // RAM word with the same index keeps its value
      issue(a | MMAP_RAM_BASE, 32'h0, 4'h0);
    end
    // Unknown CLINT offset reads zero and leaves MSIP alone
    issue(clint_addr(16'h0008), rnd(), 4'hF);
    issue(clint_addr(16'h0008), 32'h0, 4'h0);
    check_irqs(1'b0, 1'b0);

    idle(1);
    while (exp_due.size() != 0) begin
      @(posedge clk_i);
    end
    idle(2);
    $display("checks done: %0d value mismatches, %0d other errors", mism_cnt, fail_cnt);
    if (mism_cnt + fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
design/soc_pkg.sv
design/bus_decoder.sv
design/main_ram.sv
design/clint.sv
design/resp_pipe.sv
design/soc_fabric.sv
bench/tb_soc_fabric.sv

// ==== design/bus_decoder.sv ====
// Request address decoder
`timescale 1ns/10ps

module bus_decoder (
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::target_e  tgt_o,
  output logic              req_valid_o,
  output logic              ram_acc_o,
  output logic              clint_acc_o
);

  import soc_pkg::*;

  // ========================================
  // Target selection
  // ========================================
  always_comb begin
    // Unmapped unless a region matches
    tgt_o = TGT_NONE;
    if (req_i.valid) begin
      // RAM has priority over the CLINT region
      if ((req_i.addr & RAM_MASK) == MMAP_RAM_BASE) begin
        tgt_o = TGT_RAM;
      end else if ((req_i.addr & REGION_MASK) == MMAP_CLINT_BASE) begin
        tgt_o = TGT_CLINT;
      end
    end
  end

  // ========================================
  // Access strobes
  // ========================================
  // Unmapped requests still need a response slot
  assign req_valid_o = req_i.valid;

  // One-cycle strobes, only to the addressed target
  assign ram_acc_o   = (tgt_o == TGT_RAM);
  assign clint_acc_o = (tgt_o == TGT_CLINT);

endmodule

// ==== design/clint.sv ====
// Core-local interruptor
`timescale 1ns/10ps

module clint (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         acc_i,
  input  soc_pkg::bus_req_t            req_i,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o,
  output logic                         timer_irq_o,
  output logic                         sw_irq_o
);

  import soc_pkg::*;

  // ========================================
  // Registers and decode
  // ========================================
  logic [63:0]       mtime_q;
  logic [63:0]       mtimecmp_q;
  logic              msip_q;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rd_val;
  clint_reg_e        reg_sel;
  logic              wr_en;
  logic              rd_en;
  logic              mtime_wr;

  // Offset to register select
  always_comb begin
    case (req_i.addr[15:0])
      CLINT_MSIP_OFF:             reg_sel = REG_MSIP;
      CLINT_MTIMECMP_OFF:         reg_sel = REG_MTIMECMP_LO;
      CLINT_MTIMECMP_OFF + 16'd4: reg_sel = REG_MTIMECMP_HI;
      CLINT_MTIME_OFF:            reg_sel = REG_MTIME_LO;
      CLINT_MTIME_OFF + 16'd4:    reg_sel = REG_MTIME_HI;
      default:                    reg_sel = REG_NONE;
    endcase
  end

  // Any strobe bit makes it a write
  assign wr_en    = acc_i & (|req_i.wstrb);
  assign rd_en    = acc_i & ~(|req_i.wstrb);
  assign mtime_wr = wr_en & ((reg_sel == REG_MTIME_LO) | (reg_sel == REG_MTIME_HI));

  // ========================================
  // Register writes and mtime count
  // ========================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      // Free-running unless software loads it
      if (!mtime_wr) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr_en) begin
        case (reg_sel)
          REG_MSIP:        msip_q <= req_i.wdata[0];
          REG_MTIMECMP_LO: mtimecmp_q[31:0] <= req_i.wdata;
          REG_MTIMECMP_HI: mtimecmp_q[63:32] <= req_i.wdata;
          REG_MTIME_LO:    mtime_q[31:0] <= req_i.wdata;
          REG_MTIME_HI:    mtime_q[63:32] <= req_i.wdata;
          default:         ;
        endcase
      end
    end
  end

  // ========================================
  // Read path
  // ========================================
  always_comb begin
    case (reg_sel)
      REG_MSIP:        rd_val = {{(DATA_W-1){1'b0}}, msip_q};
      REG_MTIMECMP_LO: rd_val = mtimecmp_q[31:0];
      REG_MTIMECMP_HI: rd_val = mtimecmp_q[63:32];
      REG_MTIME_LO:    rd_val = mtime_q[31:0];
      REG_MTIME_HI:    rd_val = mtime_q[63:32];
      default:         rd_val = '0;
    endcase
  end

  // Value seen in the request cycle
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rd_val;
    end
  end

  assign rdata_o = rdata_q;

  // Interrupts straight from the registers
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

endmodule

// ==== design/main_ram.sv ====
// Byte-strobed main RAM
`timescale 1ns/10ps

module main_ram #(
  parameter int unsigned RAM_WORDS = 1024
) (
  input  logic                         clk_i,
  input  logic                         acc_i,
  input  soc_pkg::bus_req_t            req_i,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o
);

  import soc_pkg::*;

  // Index and byte offset widths
  localparam int unsigned IDX_W = $clog2(RAM_WORDS);
  localparam int unsigned OFF_W = $clog2(STRB_W);

  // ========================================
  // Storage
  // ========================================
  logic [DATA_W-1:0] mem_q [RAM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]  idx;

  // Word index, wraps modulo RAM_WORDS
  assign idx = req_i.addr[OFF_W +: IDX_W];

  // ========================================
  // Access port
  // ========================================
  always_ff @(posedge clk_i) begin
    if (acc_i) begin
      if (|req_i.wstrb) begin
        // Merge only the strobed bytes
        for (int b = 0; b < STRB_W; b++) begin
          if (req_i.wstrb[b]) begin
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        // Read word held until the next read
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== design/resp_pipe.sv ====
// Fixed-latency response pipeline
`timescale 1ns/10ps

module resp_pipe #(
  parameter int unsigned RESP_LATENCY = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_valid_i,
  input  soc_pkg::target_e             tgt_i,
  input  logic                         is_write_i,
  input  logic [soc_pkg::DATA_W-1:0]   ram_rdata_i,
  input  logic [soc_pkg::DATA_W-1:0]   clint_rdata_i,
  output soc_pkg::bus_rsp_t            rsp_o
);

  import soc_pkg::*;

  // Capture register counts as the first edge
  localparam int unsigned STAGES = RESP_LATENCY - 1;

  logic     req_vld_q;
  target_e  tgt_q;
  logic     is_write_q;
  bus_rsp_t rsp_d;
  bus_rsp_t pipe_q [STAGES];

  // ========================================
  // Request capture
  // ========================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_vld_q  <= 1'b0;
      tgt_q      <= TGT_NONE;
      is_write_q <= 1'b0;
    end else begin
      req_vld_q  <= req_valid_i;
      tgt_q      <= tgt_i;
      is_write_q <= is_write_i;
    end
  end

  // ========================================
  // Response build
  // ========================================
  always_comb begin
    rsp_d.valid = req_vld_q;
    // Unmapped space flags an error
    rsp_d.err   = req_vld_q & (tgt_q == TGT_NONE);
    rsp_d.rdata = '0;
    // Writes answer with zero data
    if (req_vld_q && !is_write_q) begin
      case (tgt_q)
        TGT_RAM:   rsp_d.rdata = ram_rdata_i;
        TGT_CLINT: rsp_d.rdata = clint_rdata_i;
        default:   rsp_d.rdata = '0;
      endcase
    end
  end

  // ========================================
  // Delay line
  // ========================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < STAGES; i++) begin
        pipe_q[i] <= '0;
      end
    end else begin
      pipe_q[0] <= rsp_d;
      // One slot per cycle, full rate
      for (int i = 1; i < STAGES; i++) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  assign rsp_o = pipe_q[STAGES-1];

endmodule

// ==== design/soc_fabric.sv ====
// Memory bus fabric top level
`timescale 1ns/10ps

module soc_fabric #(
  parameter int unsigned RAM_WORDS    = 1024,
  parameter int unsigned RESP_LATENCY = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o,
  output logic              timer_irq_o,
  output logic              sw_irq_o
);

  import soc_pkg::*;

  // ========================================
  // Internal nets
  // ========================================
  target_e           tgt;
  logic              req_valid;
  logic              ram_acc;
  logic              clint_acc;
  logic              is_write;
  logic [DATA_W-1:0] ram_rdata;
  logic [DATA_W-1:0] clint_rdata;

  // Write when any byte strobe is set
  assign is_write = |req_i.wstrb;

  // Address decode
  bus_decoder u_decoder (
    .req_i       (req_i),
    .tgt_o       (tgt),
    .req_valid_o (req_valid),
    .ram_acc_o   (ram_acc),
    .clint_acc_o (clint_acc)
  );

  // ========================================
  // Targets
  // ========================================
  main_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .clk_i   (clk_i),
    .acc_i   (ram_acc),
    .req_i   (req_i),
    .rdata_o (ram_rdata)
  );

  clint u_clint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .acc_i       (clint_acc),
    .req_i       (req_i),
    .rdata_o     (clint_rdata),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

  // ========================================
  // Response path
  // ========================================
  resp_pipe #(
    .RESP_LATENCY (RESP_LATENCY)
  ) u_resp_pipe (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid),
    .tgt_i         (tgt),
    .is_write_i    (is_write),
    .ram_rdata_i   (ram_rdata),
    .clint_rdata_i (clint_rdata),
    .rsp_o         (rsp_o)
  );

endmodule

// ==== design/soc_pkg.sv ====
// Fabric memory map and bus types
package soc_pkg;

  // ========================================
  // Bus widths
  // ========================================
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // ========================================
  // Memory map
  // ========================================
  // Region decode masks
  localparam logic [ADDR_W-1:0] REGION_MASK = 32'hF000_0000;
  localparam logic [ADDR_W-1:0] RAM_MASK    = 32'h8000_0000;

  // Region bases
  localparam logic [ADDR_W-1:0] MMAP_RAM_BASE   = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] MMAP_CLINT_BASE = 32'h3000_0000;

  // CLINT register offsets, low 16 address bits
  localparam logic [15:0] CLINT_MSIP_OFF     = 16'h0000;
  localparam logic [15:0] CLINT_MTIMECMP_OFF = 16'h4000;
  localparam logic [15:0] CLINT_MTIME_OFF    = 16'hBFF8;

  // ========================================
  // Bus structs
  // ========================================
  // Request, write when any strobe bit is set
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } bus_req_t;

  // Response, one per request
  typedef struct packed {
    logic              valid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // ========================================
  // Enums
  // ========================================
  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_RAM,
    TGT_CLINT
  } target_e;

  typedef enum logic [2:0] {
    REG_MSIP,
    REG_MTIMECMP_LO,
    REG_MTIMECMP_HI,
    REG_MTIME_LO,
    REG_MTIME_HI,
    REG_NONE
  } clint_reg_e;

endpackage
